// File: src.f
source/aluStagePkg.sv
source/stageIf.sv
source/operandForward.sv
source/executeLatch.sv
source/conditionCheck.sv
source/psrUpdate.sv
source/resultSelect.sv
source/executeStage.sv
testbench/executeStage_props.sv
testbench/executeStageTb.sv

// File: Bender.yml
package:
  name: executeStage

sources:
  - source/aluStagePkg.sv
  - source/stageIf.sv
  - source/operandForward.sv
  - source/executeLatch.sv
  - source/conditionCheck.sv
  - source/psrUpdate.sv
  - source/resultSelect.sv
  - source/executeStage.sv
  - target: test
    files:
      - testbench/executeStage_props.sv
      - testbench/executeStageTb.sv

// File: testbench/executeStageTb.sv
`timescale 1ns/1ps

module executeStageTb;

	localparam int resetCycles = 16;
	localparam int forwardCycles = 48;
	localparam int psrCount = 12;
	localparam int branchRounds = 6;
	localparam int stallRounds = 2;
	// six tests, each with one drain cycle
	localparam int totalCycles = resetCycles + 4 + forwardCycles + 16 + psrCount
		+ 4 * branchRounds + 6 * stallRounds + 6;

	typedef struct packed
	{
		logic valid;
		aluStagePkg::aluType_t aluType;
		aluStagePkg::simpleType_t simpleType;
		aluStagePkg::word_t left;
		aluStagePkg::word_t right;
		aluStagePkg::word_t cpsr;
		aluStagePkg::word_t spsr;
		aluStagePkg::cond_t condition;
		aluStagePkg::psrType_t psrType;
		logic isBranch;
		logic changeState;
		aluStagePkg::mode_t stateAction;
		aluStagePkg::word_t nextAddress;
		aluStagePkg::regSel_t target;
		aluStagePkg::regSel_t simpleTarget;
	} slot_t;

	typedef struct packed
	{
		logic writeEnable;
		aluStagePkg::word_t result;
		aluStagePkg::word_t simpleResult;
		aluStagePkg::word_t cpsr;
		aluStagePkg::word_t spsr;
		logic changePc;
		aluStagePkg::word_t newPc;
	} expect_t;

	logic clock = 1'b0;
	logic reset;
	logic issueValid;
	aluStagePkg::aluType_t issueType;
	aluStagePkg::simpleType_t issueSimpleType;
	aluStagePkg::regSel_t issueTarget;
	aluStagePkg::regSel_t issueSimpleTarget;
	aluStagePkg::cond_t issueCondition;
	aluStagePkg::psrType_t issuePsrType;
	logic issueIsBranch;
	logic issueChangeState;
	aluStagePkg::mode_t issueStateAction;
	aluStagePkg::word_t issueNextAddress;
	aluStagePkg::regSel_t leftReg;
	aluStagePkg::regSel_t rightReg;
	logic leftFromImm;
	logic rightFromImm;
	aluStagePkg::word_t leftBus;
	aluStagePkg::word_t rightBus;
	logic cpsrFromImm;
	logic spsrFromImm;
	aluStagePkg::word_t cpsrBus;
	aluStagePkg::word_t spsrBus;
	logic memWriteEnable;
	aluStagePkg::regSel_t memTarget;
	aluStagePkg::word_t memResult;
	aluStagePkg::word_t memCpsr;
	aluStagePkg::word_t memSpsr;
	logic wbWriteEnable;
	aluStagePkg::regSel_t wbTarget;
	aluStagePkg::word_t wbResult;
	aluStagePkg::word_t wbCpsr;
	aluStagePkg::word_t wbSpsr;
	logic memCanGo;
	logic memChangePc;
	aluStagePkg::word_t aluResult;
	logic [3:0] aluFlags;
	aluStagePkg::aluType_t execType;
	aluStagePkg::word_t execLeft;
	aluStagePkg::word_t execRight;
	logic execCarry;
	logic writeEnable;
	aluStagePkg::word_t writeResult;
	aluStagePkg::regSel_t writeTarget;
	aluStagePkg::word_t simpleResult;
	aluStagePkg::regSel_t simpleTarget;
	aluStagePkg::word_t cpsr;
	aluStagePkg::word_t spsr;
	logic changePc;
	aluStagePkg::word_t newPc;

	logic aluCarry;
	integer seed;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	slot_t model;
	logic modelKnown = 1'b0;

	executeStage UUT (.*);

	always #10 clock = ~clock;

	// external alu is a plain adder
	assign {aluCarry, aluResult} = {1'b0, execLeft} + {1'b0, execRight};
	assign aluFlags = {aluResult[31], aluResult == 32'd0, aluCarry,
		(execLeft[31] == execRight[31]) && (aluResult[31] != execLeft[31])};

	//////////////////////////////
	// reference model
	//////////////////////////////

	// each odd arm code inverts the even code below it
	function automatic logic conditionHolds(input aluStagePkg::cond_t code,
		input aluStagePkg::word_t psr);
		logic n;
		logic z;
		logic c;
		logic v;
		logic base;
		n = psr[31];
		z = psr[30];
		c = psr[29];
		v = psr[28];
		case (code[3:1])
			3'd0: base = z;
			3'd1: base = c;
			3'd2: base = n;
			3'd3: base = v;
			3'd4: base = c && !z;
			3'd5: base = (n == v);
			3'd6: base = !z && (n == v);
			default: base = 1'b1;
		endcase
		if (code == 4'd15)
			return 1'b0;
		if (code == 4'd14)
			return 1'b1;
		return code[0] ? !base : base;
	endfunction

	function automatic expect_t expectFrom(input slot_t s);
		expect_t e;
		logic [32:0] sum;
		logic [3:0] flags;
		sum = {1'b0, s.left} + {1'b0, s.right};
		flags = {sum[31], sum[31:0] == 32'd0, sum[32],
			(s.left[31] == s.right[31]) && (sum[31] != s.left[31])};
		e.writeEnable = s.valid && conditionHolds(s.condition, s.cpsr);
		e.result = e.writeEnable ? sum[31:0] : 32'd0;
		e.cpsr = s.cpsr;
		e.spsr = s.spsr;
		case (s.psrType)
			aluStagePkg::psrWriteFlags: e.cpsr[31:28] = flags;
			aluStagePkg::psrSpsrToCpsr: e.cpsr = s.spsr;
			aluStagePkg::psrRightToCpsr: e.cpsr = s.right;
			aluStagePkg::psrRightToSpsr: e.spsr = s.right;
			aluStagePkg::psrResultFlagsToCpsr: e.cpsr[31:28] = sum[31:28];
			aluStagePkg::psrResultFlagsToSpsr: e.spsr[31:28] = sum[31:28];
			aluStagePkg::psrCpsrToSpsr: e.spsr = s.cpsr;
			aluStagePkg::psrThumbFromRight: e.cpsr[5] = s.right[0];
			default: e.cpsr = s.cpsr;
		endcase
		if (s.changeState)
		begin
			e.cpsr[4:0] = s.stateAction;
			e.cpsr[5] = 1'b0;
			if (s.stateAction == 5'b10010)
				e.cpsr[7] = 1'b1;
			else if (s.stateAction == 5'b10001)
				e.cpsr[7:6] = 2'b11;
		end
		case (s.simpleType)
			3'd1: e.simpleResult = s.left;
			3'd2: e.simpleResult = s.right;
			3'd3: e.simpleResult = s.cpsr;
			3'd4: e.simpleResult = s.spsr;
			3'd5:
			begin
				e.simpleResult = s.nextAddress;
				e.simpleResult[0] = s.cpsr[5];
			end
			default: e.simpleResult = 32'd0;
		endcase
		e.changePc = s.isBranch && e.writeEnable;
		// bit 1 survives only in thumb state
		e.newPc = sum[31:0];
		e.newPc[0] = 1'b0;
		if (!e.cpsr[5])
			e.newPc[1] = 1'b0;
		return e;
	endfunction

	function automatic aluStagePkg::word_t forwardOperand(input logic fromImm,
		input aluStagePkg::regSel_t source, input aluStagePkg::word_t bus,
		input slot_t s, input expect_t e);
		if (fromImm)
			return bus;
		if (e.writeEnable && s.target == source)
			return e.result;
		if (e.writeEnable && s.simpleTarget == source)
			return e.simpleResult;
		if (memWriteEnable && memTarget == source)
			return memResult;
		if (wbWriteEnable && wbTarget == source)
			return wbResult;
		return bus;
	endfunction

	function automatic aluStagePkg::word_t forwardPsr(input logic fromImm,
		input aluStagePkg::word_t bus, input logic ownWrite, input aluStagePkg::word_t ownPsr,
		input aluStagePkg::word_t memPsr, input aluStagePkg::word_t wbPsr);
		if (fromImm)
			return bus;
		if (ownWrite)
			return ownPsr;
		if (memWriteEnable)
			return memPsr;
		if (wbWriteEnable)
			return wbPsr;
		return bus;
	endfunction

	// model follows each accepting edge
	always @(posedge clock)
	begin
		expect_t current;
		slot_t next;
		current = expectFrom(model);
		next = model;
		if (!reset)
		begin
			modelKnown = 1'b0;
			next.valid = 1'b0;
		end
		else if (memCanGo)
		begin
			next.valid = issueValid && !(current.changePc || memChangePc);
			next.aluType = issueType;
			next.simpleType = issueSimpleType;
			next.condition = issueCondition;
			next.psrType = issuePsrType;
			next.isBranch = issueIsBranch;
			next.changeState = issueChangeState;
			next.stateAction = issueStateAction;
			next.nextAddress = issueNextAddress;
			next.target = issueTarget;
			next.simpleTarget = issueSimpleTarget;
			next.left = forwardOperand(leftFromImm, leftReg, leftBus, model, current);
			next.right = forwardOperand(rightFromImm, rightReg, rightBus, model, current);
			next.cpsr = forwardPsr(cpsrFromImm, cpsrBus, current.writeEnable, current.cpsr,
				memCpsr, wbCpsr);
			next.spsr = forwardPsr(spsrFromImm, spsrBus, current.writeEnable, current.spsr,
				memSpsr, wbSpsr);
			modelKnown = 1'b1;
		end
		if (!next.valid)
		begin
			next.condition = 4'd15;
			next.psrType = 4'd0;
			next.simpleType = 3'd0;
			next.isBranch = 1'b0;
			next.changeState = 1'b0;
		end
		model = next;
	end

	//////////////////////////////
	// comparison
	//////////////////////////////

	task automatic compareValue(input string name, input aluStagePkg::word_t actual,
		input aluStagePkg::word_t expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			testErrors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic compareBit(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			testErrors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	always @(negedge clock)
	begin
		expect_t e;
		e = expectFrom(model);
		if (!reset || !modelKnown)
		begin
			compareBit("writeEnable", writeEnable, 1'b0);
			compareBit("changePc", changePc, 1'b0);
		end
		else
		begin
			compareBit("writeEnable", writeEnable, e.writeEnable);
			compareBit("changePc", changePc, e.changePc);
			compareBit("execCarry", execCarry, model.cpsr[29]);
			compareValue("writeResult", writeResult, e.result);
			compareValue("simpleResult", simpleResult, e.simpleResult);
			compareValue("cpsr", cpsr, e.cpsr);
			compareValue("spsr", spsr, e.spsr);
			if (e.changePc)
				compareValue("newPc", newPc, e.newPc);
			// payload only means something in a valid slot
			if (model.valid)
			begin
				compareValue("execLeft", execLeft, model.left);
				compareValue("execRight", execRight, model.right);
				compareValue("execType", {24'd0, execType}, {24'd0, model.aluType});
				compareValue("writeTarget", {28'd0, writeTarget}, {28'd0, model.target});
				compareValue("simpleTarget", {28'd0, simpleTarget}, {28'd0, model.simpleTarget});
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	function automatic aluStagePkg::word_t nextRandom();
		return $random(seed);
	endfunction

	// small register set so targets overlap often
	function automatic aluStagePkg::regSel_t randomReg();
		aluStagePkg::word_t r;
		r = nextRandom();
		return {2'b00, r[1:0]};
	endfunction

	function automatic logic oneInFour();
		aluStagePkg::word_t r;
		r = nextRandom();
		return r[1:0] == 2'b00;
	endfunction

	task automatic initInputs();
		reset = 1'b0;
		issueValid = 1'b0;
		issueType = '0;
		issueSimpleType = '0;
		issueTarget = '0;
		issueSimpleTarget = '0;
		issueCondition = 4'd15;
		issuePsrType = '0;
		issueIsBranch = 1'b0;
		issueChangeState = 1'b0;
		issueStateAction = '0;
		issueNextAddress = '0;
		leftReg = '0;
		rightReg = '0;
		leftFromImm = 1'b0;
		rightFromImm = 1'b0;
		leftBus = '0;
		rightBus = '0;
		cpsrFromImm = 1'b1;
		spsrFromImm = 1'b1;
		cpsrBus = '0;
		spsrBus = '0;
		memWriteEnable = 1'b0;
		memTarget = '0;
		memResult = '0;
		memCpsr = '0;
		memSpsr = '0;
		wbWriteEnable = 1'b0;
		wbTarget = '0;
		wbResult = '0;
		wbCpsr = '0;
		wbSpsr = '0;
		memCanGo = 1'b1;
		memChangePc = 1'b0;
	endtask

	task automatic driveRandom();
		aluStagePkg::word_t r;
		r = nextRandom();
		issueValid <= 1'b1;
		issueType <= r[7:0];
		issueSimpleType <= aluStagePkg::simpleType_t'(r[15:8] % 6);
		issueTarget <= randomReg();
		issueSimpleTarget <= randomReg();
		issueCondition <= aluStagePkg::condAl;
		issuePsrType <= aluStagePkg::psrType_t'(r[23:16] % 9);
		issueIsBranch <= 1'b0;
		issueChangeState <= 1'b0;
		issueStateAction <= r[28:24];
		issueNextAddress <= nextRandom();
		leftReg <= randomReg();
		rightReg <= randomReg();
		leftFromImm <= oneInFour();
		rightFromImm <= oneInFour();
		leftBus <= nextRandom();
		rightBus <= nextRandom();
		cpsrFromImm <= oneInFour();
		spsrFromImm <= oneInFour();
		cpsrBus <= nextRandom();
		spsrBus <= nextRandom();
		memWriteEnable <= !oneInFour();
		memTarget <= randomReg();
		memResult <= nextRandom();
		memCpsr <= nextRandom();
		memSpsr <= nextRandom();
		wbWriteEnable <= !oneInFour();
		wbTarget <= randomReg();
		wbResult <= nextRandom();
		wbCpsr <= nextRandom();
		wbSpsr <= nextRandom();
		memCanGo <= 1'b1;
		memChangePc <= 1'b0;
	endtask

	task automatic driveIdle();
		issueValid <= 1'b0;
		issueIsBranch <= 1'b0;
		memCanGo <= 1'b1;
		memChangePc <= 1'b0;
	endtask

	// drain the last instruction, then report
	task automatic finishTest(input string name);
		@(posedge clock);
		driveIdle();
		@(negedge clock);
		$display("test %s done with %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	task automatic branchTest();
		for (int round = 0; round < branchRounds; round++)
		begin
			@(posedge clock);
			driveRandom();
			issueIsBranch <= 1'b1;
			if (round % 2 == 1)
				issuePsrType <= aluStagePkg::psrThumbFromRight;
			@(posedge clock);
			driveRandom();
			@(negedge clock);
			compareBit("changePc after branch", changePc, 1'b1);
			// the instruction behind the branch is dropped
			@(posedge clock);
			driveRandom();
			memChangePc <= 1'b1;
			@(negedge clock);
			compareBit("writeEnable after own flush", writeEnable, 1'b0);
			@(posedge clock);
			driveIdle();
			@(negedge clock);
			compareBit("writeEnable after memory flush", writeEnable, 1'b0);
		end
	endtask

	task automatic stallTest();
		aluStagePkg::word_t heldCpsr;
		aluStagePkg::word_t heldResult;
		aluStagePkg::word_t heldSimple;
		aluStagePkg::word_t heldLeft;
		for (int round = 0; round < stallRounds; round++)
		begin
			@(posedge clock);
			driveRandom();
			@(posedge clock);
			driveRandom();
			memCanGo <= 1'b0;
			@(negedge clock);
			heldCpsr = cpsr;
			heldResult = writeResult;
			heldSimple = simpleResult;
			heldLeft = execLeft;
			repeat (3)
			begin
				@(negedge clock);
				compareValue("cpsr during stall", cpsr, heldCpsr);
				compareValue("writeResult during stall", writeResult, heldResult);
				compareValue("simpleResult during stall", simpleResult, heldSimple);
				compareValue("execLeft during stall", execLeft, heldLeft);
			end
			// held instruction goes in on the next edge
			@(posedge clock);
			memCanGo <= 1'b1;
		end
	endtask

	initial
	begin
		seed = 9;
		initInputs();

		// random traffic during reset must not write
		repeat (resetCycles)
		begin
			@(posedge clock);
			driveRandom();
		end
		reset <= 1'b1;
		driveIdle();
		repeat (4)
			@(posedge clock);
		finishTest("reset");

		repeat (forwardCycles)
		begin
			@(posedge clock);
			driveRandom();
		end
		finishTest("forwarding");

		for (int code = 0; code < 16; code++)
		begin
			@(posedge clock);
			driveRandom();
			issueCondition <= aluStagePkg::cond_t'(code);
			cpsrFromImm <= 1'b1;
		end
		finishTest("condition");

		for (int i = 0; i < psrCount; i++)
		begin
			@(posedge clock);
			driveRandom();
			if (i < 9)
				issuePsrType <= aluStagePkg::psrType_t'(i);
			else
			begin
				issueChangeState <= 1'b1;
				if (i == 9)
					issueStateAction <= aluStagePkg::modeIrq;
				else if (i == 10)
					issueStateAction <= aluStagePkg::modeFiq;
				else
					issueStateAction <= 5'b10011;
			end
		end
		finishTest("psr");

		branchTest();
		finishTest("branch");

		stallTest();
		finishTest("stall");

		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, UUT.props.failCount);
		if (errorCount == 0 && UUT.props.failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		#(2 * totalCycles * 20);
		$display("watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: testbench/executeStage_props.sv
`timescale 1ns/1ps

module executeStageProps
(
	input logic clock,
	input logic reset,
	input logic memCanGo,
	input logic writeEnable,
	input logic changePc,
	input aluStagePkg::word_t cpsr
);

	int failCount = 0;

	// no register write while the stage is held in reset
	noWriteInReset: assert property (@(negedge clock) !reset |-> !writeEnable)
	else
	begin
		failCount++;
		$error("writeEnable high while reset is low");
	end

	// a taken branch always passes its condition
	branchNeedsWrite: assert property (@(posedge clock) disable iff (!reset)
		changePc |-> writeEnable)
	else
	begin
		failCount++;
		$error("changePc high without writeEnable");
	end

	// held slot keeps its psr
	cpsrHeldOnStall: assert property (@(posedge clock) disable iff (!reset)
		!memCanGo |=> $stable(cpsr))
	else
	begin
		failCount++;
		$error("cpsr changed during a stall");
	end

endmodule

bind executeStage executeStageProps props
(
	.clock(clock),
	.reset(reset),
	.memCanGo(memCanGo),
	.writeEnable(writeEnable),
	.changePc(changePc),
	.cpsr(cpsr)
);

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
	input logic clock,
	input logic reset,
	input logic issueValid,
	input aluStagePkg::aluType_t issueType,
	input aluStagePkg::simpleType_t issueSimpleType,
	input aluStagePkg::regSel_t issueTarget,
	input aluStagePkg::regSel_t issueSimpleTarget,
	input aluStagePkg::cond_t issueCondition,
	input aluStagePkg::psrType_t issuePsrType,
	input logic issueIsBranch,
	input logic issueChangeState,
	input aluStagePkg::mode_t issueStateAction,
	input aluStagePkg::word_t issueNextAddress,
	input aluStagePkg::regSel_t leftReg,
	input aluStagePkg::regSel_t rightReg,
	input logic leftFromImm,
	input logic rightFromImm,
	input aluStagePkg::word_t leftBus,
	input aluStagePkg::word_t rightBus,
	input logic cpsrFromImm,
	input logic spsrFromImm,
	input aluStagePkg::word_t cpsrBus,
	input aluStagePkg::word_t spsrBus,
	input logic memWriteEnable,
	input aluStagePkg::regSel_t memTarget,
	input aluStagePkg::word_t memResult,
	input aluStagePkg::word_t memCpsr,
	input aluStagePkg::word_t memSpsr,
	input logic wbWriteEnable,
	input aluStagePkg::regSel_t wbTarget,
	input aluStagePkg::word_t wbResult,
	input aluStagePkg::word_t wbCpsr,
	input aluStagePkg::word_t wbSpsr,
	input logic memCanGo,
	input logic memChangePc,
	input aluStagePkg::word_t aluResult,
	input logic [3:0] aluFlags,
	output aluStagePkg::aluType_t execType,
	output aluStagePkg::word_t execLeft,
	output aluStagePkg::word_t execRight,
	output logic execCarry,
	output logic writeEnable,
	output aluStagePkg::word_t writeResult,
	output aluStagePkg::regSel_t writeTarget,
	output aluStagePkg::word_t simpleResult,
	output aluStagePkg::regSel_t simpleTarget,
	output aluStagePkg::word_t cpsr,
	output aluStagePkg::word_t spsr,
	output logic changePc,
	output aluStagePkg::word_t newPc
);

	stageState stateBus();
	stageResult resultBus();

	aluStagePkg::word_t leftOperand;
	aluStagePkg::word_t rightOperand;
	aluStagePkg::word_t newCpsr;
	aluStagePkg::word_t newSpsr;

	//////////////////////////////
	// operand forwarding
	//////////////////////////////

	operandForward leftForward
	(
		.fromImm(leftFromImm),
		.source(leftReg),
		.readBus(leftBus),
		.own(resultBus),
		.memWriteEnable(memWriteEnable),
		.memTarget(memTarget),
		.memResult(memResult),
		.wbWriteEnable(wbWriteEnable),
		.wbTarget(wbTarget),
		.wbResult(wbResult),
		.operand(leftOperand)
	);

	operandForward rightForward
	(
		.fromImm(rightFromImm),
		.source(rightReg),
		.readBus(rightBus),
		.own(resultBus),
		.memWriteEnable(memWriteEnable),
		.memTarget(memTarget),
		.memResult(memResult),
		.wbWriteEnable(wbWriteEnable),
		.wbTarget(wbTarget),
		.wbResult(wbResult),
		.operand(rightOperand)
	);

	executeLatch latch
	(
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issueType(issueType),
		.issueSimpleType(issueSimpleType),
		.issueTarget(issueTarget),
		.issueSimpleTarget(issueSimpleTarget),
		.issueCondition(issueCondition),
		.issuePsrType(issuePsrType),
		.issueIsBranch(issueIsBranch),
		.issueChangeState(issueChangeState),
		.issueStateAction(issueStateAction),
		.issueNextAddress(issueNextAddress),
		.cpsrFromImm(cpsrFromImm),
		.spsrFromImm(spsrFromImm),
		.cpsrBus(cpsrBus),
		.spsrBus(spsrBus),
		.memWriteEnable(memWriteEnable),
		.memCpsr(memCpsr),
		.memSpsr(memSpsr),
		.wbWriteEnable(wbWriteEnable),
		.wbCpsr(wbCpsr),
		.wbSpsr(wbSpsr),
		.memCanGo(memCanGo),
		.memChangePc(memChangePc),
		.left(leftOperand),
		.right(rightOperand),
		.own(resultBus),
		.state(stateBus)
	);

	//////////////////////////////
	// result side
	//////////////////////////////

	conditionCheck condition
	(
		.state(stateBus),
		.writeEnable(writeEnable)
	);

	psrUpdate psr
	(
		.state(stateBus),
		.aluFlags(aluFlags),
		.aluResult(aluResult),
		.newCpsr(newCpsr),
		.newSpsr(newSpsr)
	);

	resultSelect select
	(
		.state(stateBus),
		.writeEnable(writeEnable),
		.newCpsr(newCpsr),
		.newSpsr(newSpsr),
		.aluResult(aluResult),
		.result(resultBus),
		.changePc(changePc),
		.newPc(newPc)
	);

	// operands and carry go out to the external alu
	assign execType = stateBus.aluType;
	assign execLeft = stateBus.left;
	assign execRight = stateBus.right;
	assign execCarry = stateBus.cpsr[aluStagePkg::carryPos];

	assign writeResult = resultBus.result;
	assign writeTarget = resultBus.target;
	assign simpleResult = resultBus.simpleResult;
	assign simpleTarget = resultBus.simpleTarget;
	assign cpsr = resultBus.cpsr;
	assign spsr = resultBus.spsr;

endmodule

// File: source/resultSelect.sv
`timescale 1ns/1ps

module resultSelect
(
	stageState.consumer state,
	input logic writeEnable,
	input aluStagePkg::word_t newCpsr,
	input aluStagePkg::word_t newSpsr,
	input aluStagePkg::word_t aluResult,
	stageResult.producer result,
	output logic changePc,
	output aluStagePkg::word_t newPc
);

	assign result.writeEnable = writeEnable;
	assign result.result = writeEnable ? aluResult : '0;
	assign result.target = state.target;
	assign result.simpleTarget = state.simpleTarget;
	assign result.cpsr = newCpsr;
	assign result.spsr = newSpsr;

	// simple move unit
	always_comb
	begin
		case (state.simpleType)
			aluStagePkg::simpleLeft: result.simpleResult = state.left;
			aluStagePkg::simpleRight: result.simpleResult = state.right;
			aluStagePkg::simpleCpsr: result.simpleResult = state.cpsr;
			aluStagePkg::simpleSpsr: result.simpleResult = state.spsr;
			// return address carries the current state in bit 0
			aluStagePkg::simpleNextAddress:
				result.simpleResult = {state.nextAddress[31:1],
					state.cpsr[aluStagePkg::thumbPos]};
			default: result.simpleResult = '0;
		endcase
	end

	// halfword aligned in thumb, word aligned otherwise
	assign changePc = state.isBranch && writeEnable;
	assign newPc = {aluResult[31:2], newCpsr[aluStagePkg::thumbPos] & aluResult[1], 1'b0};

endmodule

// File: source/psrUpdate.sv
`timescale 1ns/1ps

module psrUpdate
(
	stageState.consumer state,
	input logic [3:0] aluFlags,
	input aluStagePkg::word_t aluResult,
	output aluStagePkg::word_t newCpsr,
	output aluStagePkg::word_t newSpsr
);

	always_comb
	begin
		newCpsr = state.cpsr;
		newSpsr = state.spsr;

		case (state.psrType)
			// nzcv straight from the alu
			aluStagePkg::psrWriteFlags:
				newCpsr[aluStagePkg::negPos:aluStagePkg::overflowPos] = aluFlags;
			aluStagePkg::psrSpsrToCpsr:
				newCpsr = state.spsr;
			aluStagePkg::psrRightToCpsr:
				newCpsr = state.right;
			aluStagePkg::psrRightToSpsr:
				newSpsr = state.right;
			// msr flag-only forms
			aluStagePkg::psrResultFlagsToCpsr:
				newCpsr[31:28] = aluResult[31:28];
			aluStagePkg::psrResultFlagsToSpsr:
				newSpsr[31:28] = aluResult[31:28];
			aluStagePkg::psrCpsrToSpsr:
				newSpsr = state.cpsr;
			// bx, target bit 0 selects thumb
			aluStagePkg::psrThumbFromRight:
				newCpsr[aluStagePkg::thumbPos] = state.right[0];
			default:
			begin
				newCpsr = state.cpsr;
				newSpsr = state.spsr;
			end
		endcase

		//////////////////////////////
		// exception entry
		//////////////////////////////
		if (state.changeState)
		begin
			newCpsr[4:0] = state.stateAction;
			newCpsr[aluStagePkg::thumbPos] = 1'b0;
			// irq masks irq only, fiq masks both
			if (state.stateAction == aluStagePkg::modeIrq)
			begin
				newCpsr[aluStagePkg::irqPos] = 1'b1;
			end
			else if (state.stateAction == aluStagePkg::modeFiq)
			begin
				newCpsr[aluStagePkg::irqPos] = 1'b1;
				newCpsr[aluStagePkg::fiqPos] = 1'b1;
			end
		end
	end

endmodule

// File: source/conditionCheck.sv
`timescale 1ns/1ps

module conditionCheck
(
	stageState.consumer state,
	output logic writeEnable
);

	logic n;
	logic z;
	logic c;
	logic v;
	logic holds;

	assign n = state.cpsr[aluStagePkg::negPos];
	assign z = state.cpsr[aluStagePkg::zeroPos];
	assign c = state.cpsr[aluStagePkg::carryPos];
	assign v = state.cpsr[aluStagePkg::overflowPos];

	always_comb
	begin
		case (state.condition)
			aluStagePkg::condEq: holds = z;
			aluStagePkg::condNe: holds = !z;
			aluStagePkg::condCs: holds = c;
			aluStagePkg::condCc: holds = !c;
			aluStagePkg::condMi: holds = n;
			aluStagePkg::condPl: holds = !n;
			aluStagePkg::condVs: holds = v;
			aluStagePkg::condVc: holds = !v;
			// unsigned compares
			aluStagePkg::condHi: holds = c && !z;
			aluStagePkg::condLs: holds = !c || z;
			// signed compares
			aluStagePkg::condGe: holds = (n == v);
			aluStagePkg::condLt: holds = (n != v);
			aluStagePkg::condGt: holds = !z && (n == v);
			aluStagePkg::condLe: holds = z || (n != v);
			aluStagePkg::condAl: holds = 1'b1;
			aluStagePkg::condNv: holds = 1'b0;
			default: holds = 1'b0;
		endcase
	end

	// an empty slot never writes
	assign writeEnable = state.valid && holds;

endmodule

// File: source/executeLatch.sv
`timescale 1ns/1ps

module executeLatch
(
	input logic clock,
	input logic reset,
	input logic issueValid,
	input aluStagePkg::aluType_t issueType,
	input aluStagePkg::simpleType_t issueSimpleType,
	input aluStagePkg::regSel_t issueTarget,
	input aluStagePkg::regSel_t issueSimpleTarget,
	input aluStagePkg::cond_t issueCondition,
	input aluStagePkg::psrType_t issuePsrType,
	input logic issueIsBranch,
	input logic issueChangeState,
	input aluStagePkg::mode_t issueStateAction,
	input aluStagePkg::word_t issueNextAddress,
	input logic cpsrFromImm,
	input logic spsrFromImm,
	input aluStagePkg::word_t cpsrBus,
	input aluStagePkg::word_t spsrBus,
	input logic memWriteEnable,
	input aluStagePkg::word_t memCpsr,
	input aluStagePkg::word_t memSpsr,
	input logic wbWriteEnable,
	input aluStagePkg::word_t wbCpsr,
	input aluStagePkg::word_t wbSpsr,
	input logic memCanGo,
	input logic memChangePc,
	input aluStagePkg::word_t left,
	input aluStagePkg::word_t right,
	stageResult.observer own,
	stageState.latch state
);

	logic flush;
	logic emptySlot;
	aluStagePkg::word_t nextCpsr;
	aluStagePkg::word_t nextSpsr;

	// same priority for cpsr and spsr
	function automatic aluStagePkg::word_t pickPsr(input logic fromImm,
		input aluStagePkg::word_t bus, input logic ownWrite, input aluStagePkg::word_t ownPsr,
		input logic memWrite, input aluStagePkg::word_t memPsr,
		input logic wbWrite, input aluStagePkg::word_t wbPsr);
		if (fromImm)
			return bus;
		else if (ownWrite)
			return ownPsr;
		else if (memWrite)
			return memPsr;
		else if (wbWrite)
			return wbPsr;
		return bus;
	endfunction

	// taken branch here or in memory kills the incoming instruction
	assign flush = (state.isBranch && own.writeEnable) || memChangePc;
	assign emptySlot = flush || !issueValid;

	assign nextCpsr = pickPsr(cpsrFromImm, cpsrBus, own.writeEnable, own.cpsr,
		memWriteEnable, memCpsr, wbWriteEnable, wbCpsr);
	assign nextSpsr = pickPsr(spsrFromImm, spsrBus, own.writeEnable, own.spsr,
		memWriteEnable, memSpsr, wbWriteEnable, wbSpsr);

	//////////////////////////////
	// control part
	//////////////////////////////

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state.valid <= 1'b0;
			state.condition <= aluStagePkg::condNv;
			state.psrType <= aluStagePkg::psrNone;
			state.simpleType <= aluStagePkg::simpleNone;
			state.isBranch <= 1'b0;
			state.changeState <= 1'b0;
			state.cpsr <= '0;
			state.spsr <= '0;
		end
		else if (memCanGo)
		begin
			if (emptySlot)
			begin
				state.valid <= 1'b0;
				state.condition <= aluStagePkg::condNv;
				state.psrType <= aluStagePkg::psrNone;
				state.simpleType <= aluStagePkg::simpleNone;
				state.isBranch <= 1'b0;
				state.changeState <= 1'b0;
			end
			else
			begin
				state.valid <= 1'b1;
				state.condition <= issueCondition;
				state.psrType <= issuePsrType;
				state.simpleType <= issueSimpleType;
				state.isBranch <= issueIsBranch;
				state.changeState <= issueChangeState;
			end
			state.cpsr <= nextCpsr;
			state.spsr <= nextSpsr;
		end
	end

	// payload only matters in a valid slot
	always_ff @(posedge clock)
	begin
		if (memCanGo)
		begin
			state.aluType <= issueType;
			state.left <= left;
			state.right <= right;
			state.target <= issueTarget;
			state.simpleTarget <= issueSimpleTarget;
			state.stateAction <= issueStateAction;
			state.nextAddress <= issueNextAddress;
		end
	end

endmodule

// File: source/operandForward.sv
`timescale 1ns/1ps

module operandForward
(
	input logic fromImm,
	input aluStagePkg::regSel_t source,
	input aluStagePkg::word_t readBus,
	stageResult.observer own,
	input logic memWriteEnable,
	input aluStagePkg::regSel_t memTarget,
	input aluStagePkg::word_t memResult,
	input logic wbWriteEnable,
	input aluStagePkg::regSel_t wbTarget,
	input aluStagePkg::word_t wbResult,
	output aluStagePkg::word_t operand
);

	logic useOwnMain;
	logic useOwnSimple;
	logic useMem;
	logic useWb;

	// hit on each producer, youngest first
	assign useOwnMain = own.writeEnable && (own.target == source);
	assign useOwnSimple = own.writeEnable && (own.simpleTarget == source);
	assign useMem = memWriteEnable && (memTarget == source);
	assign useWb = wbWriteEnable && (wbTarget == source);

	always_comb
	begin
		// immediates never forward
		if (fromImm)
			operand = readBus;
		else if (useOwnMain)
			operand = own.result;
		else if (useOwnSimple)
			operand = own.simpleResult;
		else if (useMem)
			operand = memResult;
		else if (useWb)
			operand = wbResult;
		else
			operand = readBus;
	end

endmodule

// File: source/stageIf.sv
`timescale 1ns/1ps

// latched instruction held by the execute stage
interface stageState;
	logic valid;
	aluStagePkg::aluType_t aluType;
	aluStagePkg::simpleType_t simpleType;
	aluStagePkg::word_t left;
	aluStagePkg::word_t right;
	aluStagePkg::word_t cpsr;
	aluStagePkg::word_t spsr;
	aluStagePkg::cond_t condition;
	aluStagePkg::psrType_t psrType;
	logic isBranch;
	logic changeState;
	aluStagePkg::mode_t stateAction;
	aluStagePkg::word_t nextAddress;
	aluStagePkg::regSel_t target;
	aluStagePkg::regSel_t simpleTarget;

	modport latch(output valid, aluType, simpleType, left, right, cpsr, spsr, condition,
		psrType, isBranch, changeState, stateAction, nextAddress, target, simpleTarget);
	modport consumer(input valid, aluType, simpleType, left, right, cpsr, spsr, condition,
		psrType, isBranch, changeState, stateAction, nextAddress, target, simpleTarget);
endinterface

// what the stage hands to memory, also fed back for forwarding
interface stageResult;
	logic writeEnable;
	aluStagePkg::word_t result;
	aluStagePkg::regSel_t target;
	aluStagePkg::word_t simpleResult;
	aluStagePkg::regSel_t simpleTarget;
	aluStagePkg::word_t cpsr;
	aluStagePkg::word_t spsr;

	modport producer(output writeEnable, result, target, simpleResult, simpleTarget,
		cpsr, spsr);
	modport observer(input writeEnable, result, target, simpleResult, simpleTarget,
		cpsr, spsr);
endinterface

// File: source/aluStagePkg.sv
package aluStagePkg;

	//////////////////////////////
	// widths with a meaning
	//////////////////////////////

	// data, psr and address words
	typedef logic [31:0] word_t;
	typedef logic [3:0] regSel_t;
	// opcode for the external alu
	typedef logic [7:0] aluType_t;
	typedef logic [3:0] cond_t;
	typedef logic [3:0] psrType_t;
	typedef logic [2:0] simpleType_t;
	typedef logic [4:0] mode_t;

	//////////////////////////////
	// condition field codes
	//////////////////////////////

	localparam cond_t condEq = 4'd0;
	localparam cond_t condNe = 4'd1;
	localparam cond_t condCs = 4'd2;
	localparam cond_t condCc = 4'd3;
	localparam cond_t condMi = 4'd4;
	localparam cond_t condPl = 4'd5;
	localparam cond_t condVs = 4'd6;
	localparam cond_t condVc = 4'd7;
	localparam cond_t condHi = 4'd8;
	localparam cond_t condLs = 4'd9;
	localparam cond_t condGe = 4'd10;
	localparam cond_t condLt = 4'd11;
	localparam cond_t condGt = 4'd12;
	localparam cond_t condLe = 4'd13;
	localparam cond_t condAl = 4'd14;
	localparam cond_t condNv = 4'd15;

	// psr operations
	localparam psrType_t psrNone = 4'd0;
	localparam psrType_t psrWriteFlags = 4'd1;
	localparam psrType_t psrSpsrToCpsr = 4'd2;
	localparam psrType_t psrRightToCpsr = 4'd3;
	localparam psrType_t psrRightToSpsr = 4'd4;
	localparam psrType_t psrResultFlagsToCpsr = 4'd5;
	localparam psrType_t psrResultFlagsToSpsr = 4'd6;
	localparam psrType_t psrCpsrToSpsr = 4'd7;
	localparam psrType_t psrThumbFromRight = 4'd8;

	// simple move unit
	localparam simpleType_t simpleNone = 3'd0;
	localparam simpleType_t simpleLeft = 3'd1;
	localparam simpleType_t simpleRight = 3'd2;
	localparam simpleType_t simpleCpsr = 3'd3;
	localparam simpleType_t simpleSpsr = 3'd4;
	localparam simpleType_t simpleNextAddress = 3'd5;

	// exception modes that touch the interrupt masks
	localparam mode_t modeIrq = 5'b10010;
	localparam mode_t modeFiq = 5'b10001;

	// psr bit positions
	localparam int negPos = 31;
	localparam int zeroPos = 30;
	localparam int carryPos = 29;
	localparam int overflowPos = 28;
	localparam int irqPos = 7;
	localparam int fiqPos = 6;
	localparam int thumbPos = 5;

endpackage
